/* rtl/rtc_pkg.sv */
`default_nettype none

package rtc_pkg;

	//////////////////////////////////////////////////////////////////////
	// digit types
	//////////////////////////////////////////////////////////////////////

	typedef logic [3:0] bcd_t;		// single bcd digit
	typedef logic [7:0] bcd_pair_t;	// tens in [7:4], units in [3:0]

	// set field order follows the mode button sequence
	typedef enum logic [2:0] {
		FIELD_RUN,
		FIELD_YEAR,
		FIELD_MONTH,
		FIELD_DAY,
		FIELD_HOUR,
		FIELD_MINUTE
	} set_field_t;

	//////////////////////////////////////////////////////////////////////
	// constants
	//////////////////////////////////////////////////////////////////////

	localparam int TICKS_PER_SECOND = 8;	// clk cycles per second, small for sim
	typedef logic [$clog2(TICKS_PER_SECOND + 1)-1:0] tick_count_t;
	localparam tick_count_t TICK_LAST = tick_count_t'(TICKS_PER_SECOND - 1);

	localparam bcd_pair_t BCD_ZERO    = 8'h00;
	localparam bcd_pair_t BCD_ONE     = 8'h01;
	localparam bcd_pair_t MINSEC_LAST = 8'h59;	// seconds and minutes top out here
	localparam bcd_pair_t HOUR_LAST   = 8'h23;
	localparam bcd_pair_t MONTH_LAST  = 8'h12;
	localparam bcd_pair_t YEAR_LAST   = 8'h99;	// 2099

	localparam bcd_pair_t LAST_DAY_28 = 8'h28;
	localparam bcd_pair_t LAST_DAY_29 = 8'h29;
	localparam bcd_pair_t LAST_DAY_30 = 8'h30;
	localparam bcd_pair_t LAST_DAY_31 = 8'h31;

	// pair plus one, units roll into tens
	// no wrap at 99, the caller picks its own wrap point
	function automatic bcd_pair_t bcd_inc(input bcd_pair_t value);
		bcd_t units;
		bcd_t tens;
		units = value[3:0];
		tens  = value[7:4];
		if (units == 4'd9)
		begin
			units = 4'd0;
			tens  = tens + 4'd1;
		end
		else
			units = units + 4'd1;
		return {tens, units};
	endfunction

	// binary 0..99 for magnitude compares
	function automatic logic [6:0] bcd_to_bin(input bcd_pair_t value);
		return 7'(value[7:4]) * 7'd10 + 7'(value[3:0]);
	endfunction

endpackage

`default_nettype wire

/* rtl/calendar_if.sv */
`default_nettype none

// date digits out of the date counter, day limit back from the lookup
interface calendar_if;
	import rtc_pkg::*;

	bcd_pair_t day;		// 01..31
	bcd_pair_t month;		// 01..12
	bcd_pair_t year;		// 00..99
	bcd_pair_t last_day;	// combinational from month and year

	modport counter (
		output day,
		output month,
		output year,
		input  last_day
	);

	modport limit (
		input  month,
		input  year,
		output last_day
	);

endinterface

`default_nettype wire

/* rtl/set_if.sv */
`default_nettype none

// one-cycle set strobes, never more than one high at a time
interface set_if;

	logic inc_year;
	logic inc_month;
	logic inc_day;
	logic inc_hour;
	logic inc_minute;
	logic clear_seconds;	// on exit from set mode

	modport source (
		output inc_year, inc_month, inc_day,
		output inc_hour, inc_minute,
		output clear_seconds
	);

	modport sink (
		input inc_year, inc_month, inc_day,
		input inc_hour, inc_minute,
		input clear_seconds
	);

endinterface

`default_nettype wire

/* rtl/tick_timer.sv */
`default_nettype none

module tick_timer (
	input  logic clk,
	input  logic reset,
	input  logic running,
	output logic sec_tick
);
	import rtc_pkg::*;

	tick_count_t count;	// cycles into the current second

	//////////////////////////////////////////////////////////////////////
	// prescaler
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset || !running)
			count <= '0;	// held at zero in set mode, restarts clean
		else if (count == TICK_LAST)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	// last cycle of the second
	// first tick lands TICKS_PER_SECOND edges after running goes high
	assign sec_tick = running && (count == TICK_LAST);

endmodule

`default_nettype wire

/* rtl/set_fsm.sv */
`default_nettype none

module set_fsm (
	input  logic                clk,
	input  logic                reset,
	input  logic                mode,
	input  logic                inc,
	set_if.source               set,
	output rtc_pkg::set_field_t field,
	output logic                running
);
	import rtc_pkg::*;

	set_field_t field_next;
	logic       inc_take;	// inc that counts this cycle

	// next field on a mode press
	always_comb
	begin
		unique case (field)
			FIELD_RUN:    field_next = FIELD_YEAR;
			FIELD_YEAR:   field_next = FIELD_MONTH;
			FIELD_MONTH:  field_next = FIELD_DAY;	// day after month and year
			FIELD_DAY:    field_next = FIELD_HOUR;
			FIELD_HOUR:   field_next = FIELD_MINUTE;
			FIELD_MINUTE: field_next = FIELD_RUN;
			default:      field_next = FIELD_RUN;
		endcase
	end

	// mode wins over inc, keeps clear_seconds and inc_minute apart
	assign inc_take = inc && !mode;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			field             <= FIELD_RUN;
			set.inc_year      <= 1'b0;
			set.inc_month     <= 1'b0;
			set.inc_day       <= 1'b0;
			set.inc_hour      <= 1'b0;
			set.inc_minute    <= 1'b0;
			set.clear_seconds <= 1'b0;
		end
		else
		begin
			if (mode)
				field <= field_next;
			// inc in RUN falls through to nothing
			set.inc_year      <= inc_take && (field == FIELD_YEAR);
			set.inc_month     <= inc_take && (field == FIELD_MONTH);
			set.inc_day       <= inc_take && (field == FIELD_DAY);
			set.inc_hour      <= inc_take && (field == FIELD_HOUR);
			set.inc_minute    <= inc_take && (field == FIELD_MINUTE);
			set.clear_seconds <= mode && (field == FIELD_MINUTE);	// back to RUN
		end
	end

	assign running = (field == FIELD_RUN);	// clock stopped in any set field

	// counters rely on a single strobe per cycle
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({set.inc_year, set.inc_month, set.inc_day,
			set.inc_hour, set.inc_minute, set.clear_seconds}));

endmodule

`default_nettype wire

/* rtl/time_counter.sv */
`default_nettype none

module time_counter (
	input  logic               clk,
	input  logic               reset,
	input  logic               sec_tick,
	set_if.sink                set,
	output rtc_pkg::bcd_pair_t seconds,
	output rtc_pkg::bcd_pair_t minutes,
	output rtc_pkg::bcd_pair_t hours,
	output logic               day_carry
);
	import rtc_pkg::*;

	logic sec_wrap;	// at 59
	logic min_wrap;	// at 59
	logic hour_wrap;	// at 23

	assign sec_wrap  = (seconds == MINSEC_LAST);
	assign min_wrap  = (minutes == MINSEC_LAST);
	assign hour_wrap = (hours == HOUR_LAST);

	// 23:59:59 plus one second, same cycle as the tick
	assign day_carry = sec_tick && sec_wrap && min_wrap && hour_wrap;

	//////////////////////////////////////////////////////////////////////
	// seconds, minutes, hours chain
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			seconds <= BCD_ZERO;
			minutes <= BCD_ZERO;
			hours   <= BCD_ZERO;
		end
		else if (set.clear_seconds)
			seconds <= BCD_ZERO;	// leaving set mode
		else if (set.inc_minute)
			minutes <= min_wrap ? BCD_ZERO : bcd_inc(minutes);	// no carry into hours
		else if (set.inc_hour)
			hours <= hour_wrap ? BCD_ZERO : bcd_inc(hours);
		else if (sec_tick)
		begin
			seconds <= sec_wrap ? BCD_ZERO : bcd_inc(seconds);
			if (sec_wrap)
			begin
				minutes <= min_wrap ? BCD_ZERO : bcd_inc(minutes);
				if (min_wrap)
					hours <= hour_wrap ? BCD_ZERO : bcd_inc(hours);
			end
		end
	end

	// all six digits stay decimal
	assert property (@(posedge clk) disable iff (reset)
		(seconds[3:0] < 4'd10) && (seconds[7:4] < 4'd10) &&
		(minutes[3:0] < 4'd10) && (minutes[7:4] < 4'd10) &&
		(hours[3:0] < 4'd10) && (hours[7:4] < 4'd10));

endmodule

`default_nettype wire

/* rtl/day_limit.sv */
`default_nettype none

module day_limit (
	calendar_if.limit cal
);
	import rtc_pkg::*;

	logic [6:0] year_bin;	// 0..99
	logic       leap_year;

	assign year_bin = bcd_to_bin(cal.year);

	// every fourth year is leap inside 2000..2099
	// 2000 itself is leap so the century rule never applies
	assign leap_year = (year_bin[1:0] == 2'b00);

	//////////////////////////////////////////////////////////////////////
	// month decode straight on the bcd code
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cal.month)
			8'h01, 8'h03, 8'h05, 8'h07,
			8'h08, 8'h10, 8'h12:
				cal.last_day = LAST_DAY_31;
			8'h04, 8'h06, 8'h09, 8'h11:
				cal.last_day = LAST_DAY_30;
			8'h02:
				cal.last_day = leap_year ? LAST_DAY_29 : LAST_DAY_28;	// feb
			default:
				cal.last_day = BCD_ZERO;	// not a month
		endcase
	end

endmodule

`default_nettype wire

/* rtl/date_counter.sv */
`default_nettype none

module date_counter (
	input  logic        clk,
	input  logic        reset,
	input  logic        day_carry,
	set_if.sink         set,
	calendar_if.counter cal
);
	import rtc_pkg::*;

	logic [6:0] day_bin;		// compare values
	logic [6:0] last_bin;
	logic       day_end;		// at or past the month end
	logic       day_over;	// past it, clamp pending
	logic       month_wrap;
	logic       year_wrap;

	assign day_bin    = bcd_to_bin(cal.day);
	assign last_bin   = bcd_to_bin(cal.last_day);
	assign day_end    = (day_bin >= last_bin);
	assign day_over   = (day_bin > last_bin);
	assign month_wrap = (cal.month == MONTH_LAST);
	assign year_wrap  = (cal.year == YEAR_LAST);

	//////////////////////////////////////////////////////////////////////
	// day, month, year
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cal.day   <= BCD_ONE;	// 01/01/00
			cal.month <= BCD_ONE;
			cal.year  <= BCD_ZERO;
		end
		else if (set.inc_year)
			cal.year <= year_wrap ? BCD_ZERO : bcd_inc(cal.year);
		else if (set.inc_month)
			cal.month <= month_wrap ? BCD_ONE : bcd_inc(cal.month);
		else if (set.inc_day)
			cal.day <= day_end ? BCD_ONE : bcd_inc(cal.day);	// wraps at last_day
		else if (day_carry)
		begin
			// midnight, lands on the same edge as 00:00:00
			if (day_end)
			begin
				cal.day <= BCD_ONE;
				if (month_wrap)
				begin
					cal.month <= BCD_ONE;
					cal.year  <= year_wrap ? BCD_ZERO : bcd_inc(cal.year);	// 99 to 00
				end
				else
					cal.month <= bcd_inc(cal.month);
			end
			else
				cal.day <= bcd_inc(cal.day);
		end
		else if (day_over)
			cal.day <= cal.last_day;	// month or year set left day too high
	end

	// day only above the limit right after a month or year strobe
	assert property (@(posedge clk) disable iff (reset)
		(cal.day != BCD_ZERO) &&
		(!day_over || $past(set.inc_month || set.inc_year)));

endmodule

`default_nettype wire

/* rtl/rtc_calendar.sv */
`default_nettype none

module rtc_calendar (
	input  logic                clk,
	input  logic                reset,
	input  logic                mode,	// one pulse per press
	input  logic                inc,
	output rtc_pkg::bcd_pair_t  seconds,
	output rtc_pkg::bcd_pair_t  minutes,
	output rtc_pkg::bcd_pair_t  hours,
	output rtc_pkg::bcd_pair_t  day,
	output rtc_pkg::bcd_pair_t  month,
	output rtc_pkg::bcd_pair_t  year,
	output rtc_pkg::set_field_t field,
	output logic                sec_tick
);

	logic running;	// low while a field is being set
	logic day_carry;	// midnight

	calendar_if cal_if ();
	set_if      set_bus ();

	tick_timer tick_timer_i (
		.clk      (clk),
		.reset    (reset),
		.running  (running),
		.sec_tick (sec_tick)
	);

	set_fsm set_fsm_i (
		.clk     (clk),
		.reset   (reset),
		.mode    (mode),
		.inc     (inc),
		.set     (set_bus.source),
		.field   (field),
		.running (running)
	);

	time_counter time_counter_i (
		.clk       (clk),
		.reset     (reset),
		.sec_tick  (sec_tick),
		.set       (set_bus.sink),
		.seconds   (seconds),
		.minutes   (minutes),
		.hours     (hours),
		.day_carry (day_carry)
	);

	date_counter date_counter_i (
		.clk       (clk),
		.reset     (reset),
		.day_carry (day_carry),
		.set       (set_bus.sink),
		.cal       (cal_if.counter)
	);

	day_limit day_limit_i (
		.cal (cal_if.limit)	// month end for the clamp and rollover
	);

	assign day   = cal_if.day;
	assign month = cal_if.month;
	assign year  = cal_if.year;

endmodule

`default_nettype wire

/* bench/calendar_model.svh */
`ifndef CALENDAR_MODEL_SVH
`define CALENDAR_MODEL_SVH

// date and time as plain integers, year 0..99 stands for 2000..2099
typedef struct packed {
	int year;
	int month;
	int day;
	int hour;
	int minute;
	int second;
} cal_state_t;

function automatic cal_state_t date_time(input int year, month, day, hour, minute, second);
	return {year, month, day, hour, minute, second};
endfunction

// 30 for apr jun sep nov, feb leap every fourth year
function automatic int month_length(input int month, input int year);
	int days;
	days = 31;
	if (month == 4 || month == 6 || month == 9 || month == 11)
		days = 30;
	else if (month == 2)
		days = (year % 4 == 0) ? 29 : 28;
	return days;
endfunction

function automatic logic [7:0] to_bcd(input int value);
	return {4'(value / 10), 4'(value % 10)};	// tens, units
endfunction

function automatic int field_value(input cal_state_t s, input set_field_t f);
	int value;
	case (f)
		FIELD_YEAR:   value = s.year;
		FIELD_MONTH:  value = s.month;
		FIELD_DAY:    value = s.day;
		FIELD_HOUR:   value = s.hour;
		FIELD_MINUTE: value = s.minute;
		default:      value = s.second;
	endcase
	return value;
endfunction

// one inc press, field wraps alone
function automatic cal_state_t press_field(input cal_state_t s, input set_field_t f);
	case (f)
		FIELD_YEAR:   s.year   = (s.year + 1) % 100;
		FIELD_MONTH:  s.month  = s.month % 12 + 1;
		FIELD_DAY:    s.day    = s.day % month_length(s.month, s.year) + 1;
		FIELD_HOUR:   s.hour   = (s.hour + 1) % 24;
		FIELD_MINUTE: s.minute = (s.minute + 1) % 60;
		default: ;
	endcase
	if (s.day > month_length(s.month, s.year))
		s.day = month_length(s.month, s.year);	// pulled back to month end
	return s;
endfunction

function automatic cal_state_t advance_second(input cal_state_t s);
	s.second = s.second + 1;
	if (s.second == 60)
	begin
		s.second = 0;
		s.minute = s.minute + 1;
	end
	if (s.minute == 60)
	begin
		s.minute = 0;
		s.hour   = s.hour + 1;
	end
	if (s.hour == 24)
	begin
		s.hour = 0;
		s.day  = s.day + 1;	// midnight
	end
	if (s.day > month_length(s.month, s.year))
	begin
		s.day   = 1;
		s.month = s.month + 1;
	end
	if (s.month > 12)
	begin
		s.month = 1;
		s.year  = (s.year + 1) % 100;	// 99 back to 00
	end
	return s;
endfunction

`endif

/* bench/rtc_calendar_tb.sv */
`default_nettype none

module rtc_calendar_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rtc_pkg::*;

	`include "calendar_model.svh"

	typedef struct packed {
		int         secs;		// seconds run after the set
		cal_state_t target;		// second unused, cleared on exit
		cal_state_t expected;
	} row_t;

	logic       clk;
	logic       reset;
	logic       mode;
	logic       inc;
	bcd_pair_t  seconds;
	bcd_pair_t  minutes;
	bcd_pair_t  hours;
	bcd_pair_t  day;
	bcd_pair_t  month;
	bcd_pair_t  year;
	set_field_t field;
	logic       sec_tick;

	row_t        rows[$];
	string       names[$];
	cal_state_t  cur;	// where the dut should be now
	string       test_name;
	logic [31:0] rnd_state;
	int          checks;
	int          errors;
	int          errs_before;
	int          cycle_count;
	int          cycle_limit;

	rtc_calendar rtc_calendar_i (.*);

	always #5 clk = ~clk;	// 10 ns

	// watchdog
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: run still going after %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int draw(input int span);
		rnd_state = xorshift(rnd_state);
		return int'(rnd_state % 32'(span));
	endfunction

	task automatic check(input string what, input bcd_pair_t expected,
		input bcd_pair_t actual);
		checks = checks + 1;
		if (expected !== actual)
		begin
			errors = errors + 1;
			$display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_state(input cal_state_t e);
		check("year", to_bcd(e.year), year);
		check("month", to_bcd(e.month), month);
		check("day", to_bcd(e.day), day);
		check("hours", to_bcd(e.hour), hours);
		check("minutes", to_bcd(e.minute), minutes);
		check("seconds", to_bcd(e.second), seconds);
	endtask

	// one button pulse, then room for the strobe and a clamp
	task automatic press(input logic on_mode);
		mode = on_mode;
		inc  = !on_mode;
		@(negedge clk);
		mode = 1'b0;
		inc  = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic set_to(input cal_state_t t);
		set_field_t f;
		int         ticks;
		ticks = 0;
		press(1'b1);	// into year
		repeat (2 * TICKS_PER_SECOND)
		begin
			@(negedge clk);
			if (sec_tick)
				ticks = ticks + 1;
		end
		check("ticks while setting", 8'd0, 8'(ticks));
		check("seconds held", to_bcd(cur.second), seconds);
		for (int k = 1; k <= 5; k++)
		begin
			f = set_field_t'(k);
			if (f != FIELD_YEAR)
				press(1'b1);
			check("field", 8'(f), 8'(field));
			while (field_value(cur, f) != field_value(t, f))
			begin
				press(1'b0);
				cur = press_field(cur, f);
			end
			check("day after set", to_bcd(cur.day), day);	// clamp shows here
		end
		press(1'b1);	// back to run
		check("field", 8'(FIELD_RUN), 8'(field));
		cur.second = 0;
	endtask

	task automatic run_seconds(input int n);
		int ticks;
		int gap;	// cycles since the last tick
		ticks = 0;
		gap   = 0;
		while (ticks < n)
		begin
			@(negedge clk);
			gap = gap + 1;
			if (sec_tick)
			begin
				// one pulse per second of clk cycles
				if (ticks > 0)
					check("tick spacing", 8'(TICKS_PER_SECOND), 8'(gap));
				ticks = ticks + 1;
				gap   = 0;
			end
		end
		@(negedge clk);	// counters take the last tick
		repeat (n)
			cur = advance_second(cur);
	endtask

	task automatic add_row(input string name, input cal_state_t t, input int secs,
		input cal_state_t e);
		row_t r;
		r.secs     = secs;
		r.target   = t;
		r.expected = e;
		rows.push_back(r);
		names.push_back(name);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic build_table();
		cal_state_t t;
		cal_state_t e;
		int         secs;
		add_row("minute_carry", date_time(24, 5, 10, 10, 20, 0), 75,
			date_time(24, 5, 10, 10, 21, 15));
		add_row("hour_carry", date_time(31, 7, 4, 13, 59, 0), 61,
			date_time(31, 7, 4, 14, 0, 1));
		add_row("day_rollover", date_time(10, 3, 15, 23, 59, 0), 60,
			date_time(10, 3, 16, 0, 0, 0));
		add_row("month_30", date_time(15, 4, 30, 23, 59, 0), 60,
			date_time(15, 5, 1, 0, 0, 0));
		add_row("month_31", date_time(15, 8, 31, 23, 59, 0), 60,
			date_time(15, 9, 1, 0, 0, 0));
		add_row("year_end", date_time(45, 12, 31, 23, 59, 0), 60,
			date_time(46, 1, 1, 0, 0, 0));
		add_row("year_99", date_time(99, 12, 31, 23, 59, 0), 60,
			date_time(0, 1, 1, 0, 0, 0));
		add_row("feb_leap", date_time(24, 2, 28, 23, 59, 0), 60,
			date_time(24, 2, 29, 0, 0, 0));
		add_row("feb_common", date_time(23, 2, 28, 23, 59, 0), 60,
			date_time(23, 3, 1, 0, 0, 0));
		add_row("feb_29", date_time(24, 2, 29, 23, 59, 0), 60,
			date_time(24, 3, 1, 0, 0, 0));
		add_row("set_hold", date_time(12, 11, 30, 23, 45, 0), 0,
			date_time(12, 11, 30, 23, 45, 0));
		// day, hour and minute all pass their wrap point
		add_row("set_wrap", date_time(12, 11, 5, 2, 10, 0), 0,
			date_time(12, 11, 5, 2, 10, 0));
		add_row("clamp_jan31", date_time(24, 1, 31, 12, 0, 0), 0,
			date_time(24, 1, 31, 12, 0, 0));
		add_row("clamp_feb_leap", date_time(24, 2, 29, 12, 0, 0), 0,
			date_time(24, 2, 29, 12, 0, 0));
		add_row("clamp_year", date_time(25, 2, 28, 12, 0, 0), 0,
			date_time(25, 2, 28, 12, 0, 0));
		add_row("clamp_jan31_b", date_time(25, 1, 31, 12, 0, 0), 0,
			date_time(25, 1, 31, 12, 0, 0));
		add_row("clamp_feb_common", date_time(25, 2, 28, 12, 0, 0), 0,
			date_time(25, 2, 28, 12, 0, 0));
		for (int i = 0; i < 6; i++)
		begin
			t.second = 0;
			t.year   = draw(100);
			t.month  = draw(12) + 1;
			t.day    = draw(month_length(t.month, t.year)) + 1;
			t.hour   = draw(24);
			t.minute = draw(60);
			secs     = 20 + draw(180);
			e        = t;
			repeat (secs)
				e = advance_second(e);
			add_row($sformatf("random_%0d", i), t, secs, e);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		clk         = 1'b0;
		reset       = 1'b1;
		mode        = 1'b0;
		inc         = 1'b0;
		checks      = 0;
		errors      = 0;
		cycle_count = 0;
		rnd_state   = 32'd90;
		build_table();
		cycle_limit = 210;	// reset plus slack
		foreach (rows[i])
			cycle_limit += (rows[i].secs + 3) * TICKS_PER_SECOND + 3 * (6 + 222);
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_name = "reset";
		cur = date_time(0, 1, 1, 0, 0, 0);	// 00:00:00 on 01/01/00
		check_state(cur);
		check("field", 8'(FIELD_RUN), 8'(field));
		$display("%s: %s", test_name, (errors == 0) ? "ok" : "mismatch");
		foreach (rows[i])
		begin
			test_name   = names[i];
			errs_before = errors;
			set_to(rows[i].target);
			run_seconds(rows[i].secs);
			check_state(rows[i].expected);
			$display("%s: %s", test_name, (errors == errs_before) ? "ok" : "mismatch");
		end
		$display("tests %0d, checks %0d, errors %0d", rows.size() + 1, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+bench
rtl/rtc_pkg.sv
rtl/calendar_if.sv
rtl/set_if.sv
rtl/tick_timer.sv
rtl/set_fsm.sv
rtl/time_counter.sv
rtl/day_limit.sv
rtl/date_counter.sv
rtl/rtc_calendar.sv
bench/rtc_calendar_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rtc calendar testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module rtc_calendar_tb -o rtc_calendar_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rtc_calendar_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
